//--- station_pkg.sv
`default_nettype none

package station_pkg;

  // internal signal path sample and its double-headroom working width
  typedef logic signed [17:0] sample_t;
  typedef logic signed [19:0] wide_t;

  // converter output word
  typedef logic signed [15:0] adc_t;

  // saturation limits
  localparam sample_t sample_max = 18'sh1ffff;
  localparam sample_t sample_min = -18'sh20000;
  localparam adc_t adc_max = 16'sh7fff;
  localparam adc_t adc_min = -16'sh8000;

  // dither width taken from the prng
  localparam int dither_bits = 4;

  // cavity gain is an unsigned fraction of 2^17
  localparam int gain_frac = 17;

  // galois lfsr feedback taps
  localparam logic [31:0] lfsr_taps = 32'h80200003;

  // clamp a working value to the 18-bit sample range
  function automatic sample_t sat_sample(input wide_t x);
    if (x > wide_t'(sample_max)) return sample_max;
    if (x < wide_t'(sample_min)) return sample_min;
    return sample_t'(x);
  endfunction

  // clamp a working value to the 16-bit adc range
  function automatic adc_t sat_adc(input wide_t x);
    if (x > wide_t'(adc_max)) return adc_max;
    if (x < wide_t'(adc_min)) return adc_min;
    return adc_t'(x);
  endfunction

endpackage

`default_nettype wire

//--- station_regs_pkg.sv
`default_nettype none

package station_regs_pkg;

  // local bus word types
  typedef logic [7:0] lb_addr_t;
  typedef logic [31:0] lb_data_t;

  // right-shift amount used by the filters
  typedef logic [3:0] shift_t;

  // address map
  localparam lb_addr_t addr_knee = 8'd1;
  localparam lb_addr_t addr_amp_shift = 8'd2;
  localparam lb_addr_t addr_cav_gain = 8'd3;
  localparam lb_addr_t addr_cav_shift = 8'd4;
  localparam lb_addr_t addr_adc_offset_field = 8'd5;
  localparam lb_addr_t addr_adc_offset_forward = 8'd6;
  localparam lb_addr_t addr_adc_offset_reflect = 8'd7;
  localparam lb_addr_t addr_prng_enable = 8'd8;
  localparam lb_addr_t addr_seed_a = 8'd9;
  localparam lb_addr_t addr_seed_b = 8'd10;

  // register values after reset
  // knee at full scale means no compression
  localparam station_pkg::sample_t knee_reset = station_pkg::sample_max;
  localparam shift_t amp_shift_reset = 4'd2;
  localparam logic [17:0] cav_gain_reset = 18'd0;
  localparam shift_t cav_shift_reset = 4'd4;
  localparam station_pkg::adc_t offset_reset = 16'sd0;
  localparam logic prng_enable_reset = 1'b0;
  localparam logic [31:0] seed_reset = 32'd1;

endpackage

`default_nettype wire

//--- cav_probe_if.sv
`timescale 1ns/1ps
`default_nettype none

// cavity probe bundle, one sample per cycle with interleaved phase
interface cav_probe_if;
  import station_pkg::*;

  // high marks the I sample, low the Q sample
  logic iq;

  // cavity field probe
  sample_t field;

  // forward and reflected couplers
  sample_t forward;
  sample_t reflect;

  // driven by the cavity model
  modport src (output iq, field, forward, reflect);

  // read by each adc emulator
  modport snk (input iq, field, forward, reflect);

endinterface

`default_nettype wire

//--- station_regs.sv
`timescale 1ns/1ps
`default_nettype none

module station_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       lb_write,
  input  station_regs_pkg::lb_addr_t lb_addr,
  input  station_regs_pkg::lb_data_t lb_data,
  output station_pkg::sample_t       knee,
  output station_regs_pkg::shift_t   amp_shift,
  output logic [17:0]                cav_gain,
  output station_regs_pkg::shift_t   cav_shift,
  output station_pkg::adc_t          offset_field,
  output station_pkg::adc_t          offset_forward,
  output station_pkg::adc_t          offset_reflect,
  output logic                       prng_enable,
  output logic [31:0]                seed_a,
  output logic [31:0]                seed_b,
  output logic                       seed_load_a,
  output logic                       seed_load_b
);
  import station_regs_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      knee <= knee_reset;
      amp_shift <= amp_shift_reset;
      cav_gain <= cav_gain_reset;
      cav_shift <= cav_shift_reset;
      offset_field <= offset_reset;
      offset_forward <= offset_reset;
      offset_reflect <= offset_reset;
      prng_enable <= prng_enable_reset;
      seed_a <= seed_reset;
      seed_b <= seed_reset;
      seed_load_a <= 1'b0;
      seed_load_b <= 1'b0;
    end else begin
      // load pulses last a single cycle
      seed_load_a <= 1'b0;
      seed_load_b <= 1'b0;
      if (lb_write) begin
        // data is truncated to the width of each field
        case (lb_addr)
          addr_knee: knee <= lb_data[17:0];
          addr_amp_shift: amp_shift <= lb_data[3:0];
          addr_cav_gain: cav_gain <= lb_data[17:0];
          addr_cav_shift: cav_shift <= lb_data[3:0];
          addr_adc_offset_field: offset_field <= lb_data[15:0];
          addr_adc_offset_forward: offset_forward <= lb_data[15:0];
          addr_adc_offset_reflect: offset_reflect <= lb_data[15:0];
          addr_prng_enable: prng_enable <= lb_data[0];
          addr_seed_a: begin
            seed_a <= lb_data;
            seed_load_a <= 1'b1;
          end
          addr_seed_b: begin
            seed_b <= lb_data;
            seed_load_b <= 1'b1;
          end
          // unmapped addresses fall through untouched
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- amp_compress.sv
`timescale 1ns/1ps
`default_nettype none

module amp_compress (
  input  logic                 clk,
  input  logic                 reset,
  input  station_pkg::sample_t d_in,
  input  logic                 iq,
  input  station_pkg::sample_t knee,
  output station_pkg::sample_t d_out,
  output logic                 iq_out
);
  import station_pkg::*;

  wide_t d_ext;
  wide_t knee_ext;
  wide_t mag;
  wide_t excess;
  wide_t comp_mag;
  wide_t comp;
  logic over;

  // same rule on I and Q, not a true polar compression
  assign d_ext = wide_t'(d_in);
  assign knee_ext = wide_t'(knee);

  // magnitude needs the extra bit for -2^17
  assign mag = d_ext[19] ? -d_ext : d_ext;
  assign over = mag > knee_ext;

  // above the knee the excess is halved
  assign excess = mag - knee_ext;
  assign comp_mag = knee_ext + (excess >>> 1);

  // restore the sign
  assign comp = d_ext[19] ? -comp_mag : comp_mag;

  always_ff @(posedge clk) begin
    if (reset) begin
      d_out <= '0;
      iq_out <= 1'b0;
    end else begin
      // +2^17 at full scale clamps to sample_max
      d_out <= over ? sat_sample(comp) : d_in;
      iq_out <= iq;
    end
  end

endmodule

`default_nettype wire

//--- amp_lowpass.sv
`timescale 1ns/1ps
`default_nettype none

module amp_lowpass (
  input  logic                     clk,
  input  logic                     reset,
  input  station_pkg::sample_t     d_in,
  input  logic                     iq,
  input  station_regs_pkg::shift_t shift,
  output station_pkg::sample_t     d_out,
  output logic                     iq_out
);
  import station_pkg::*;

  // one filter state per phase
  sample_t state_i;
  sample_t state_q;
  sample_t state_sel;
  wide_t err;
  wide_t next_w;

  assign state_sel = iq ? state_i : state_q;

  // error between input and state, scaled by the bandwidth shift
  assign err = wide_t'(d_in) - wide_t'(state_sel);
  // result lies between old state and input, so it always fits 18 bits
  assign next_w = wide_t'(state_sel) + (err >>> shift);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_i <= '0;
      state_q <= '0;
      d_out <= '0;
      iq_out <= 1'b0;
    end else begin
      if (iq) begin
        state_i <= sample_t'(next_w);
      end else begin
        state_q <= sample_t'(next_w);
      end
      // output is the freshly updated state
      d_out <= sample_t'(next_w);
      iq_out <= iq;
    end
  end

endmodule

`default_nettype wire

//--- cav_mode.sv
`timescale 1ns/1ps
`default_nettype none

module cav_mode (
  input  logic                     clk,
  input  logic                     reset,
  input  station_pkg::sample_t     drive,
  input  logic                     iq,
  input  logic [17:0]              gain,
  input  station_regs_pkg::shift_t shift,
  cav_probe_if.src                 probe
);
  import station_pkg::*;

  // field state per phase
  sample_t field_i;
  sample_t field_q;
  sample_t field_sel;
  sample_t field_next;

  // signed drive times unsigned gain
  logic signed [36:0] product;
  wide_t scaled;
  wide_t err;
  wide_t next_w;

  assign field_sel = iq ? field_i : field_q;

  // gain gets a zero sign bit so it stays unsigned
  assign product = drive * $signed({1'b0, gain});
  assign scaled = wide_t'(product >>> gain_frac);

  // one-pole update toward the scaled drive
  assign err = scaled - wide_t'(field_sel);
  assign next_w = wide_t'(field_sel) + (err >>> shift);

  // gains above unity can push the target past 18 bits, so the state clamps
  assign field_next = sat_sample(next_w);

  always_ff @(posedge clk) begin
    if (reset) begin
      field_i <= '0;
      field_q <= '0;
      probe.iq <= 1'b0;
      probe.field <= '0;
      probe.forward <= '0;
      probe.reflect <= '0;
    end else begin
      if (iq) begin
        field_i <= field_next;
      end else begin
        field_q <= field_next;
      end
      probe.iq <= iq;
      probe.field <= field_next;
      // forward coupler sees the amplifier output directly
      probe.forward <= drive;
      // reflected wave is what the cavity does not absorb
      probe.reflect <= sat_sample(wide_t'(field_next) - wide_t'(drive));
    end
  end

endmodule

`default_nettype wire

//--- noise_prng.sv
`timescale 1ns/1ps
`default_nettype none

module noise_prng (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic [31:0] seed_a,
  input  logic [31:0] seed_b,
  input  logic        load_a,
  input  logic        load_b,
  output logic [31:0] rnda,
  output logic [31:0] rndb
);
  import station_pkg::*;
  import station_regs_pkg::*;

  // generator 0 feeds rnda, generator 1 feeds rndb
  logic [31:0] seed [2];
  logic        load [2];
  logic [31:0] state [2];

  // one galois step, shift right and fold taps when bit 0 falls out
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? lfsr_taps : 32'd0);
  endfunction

  assign seed[0] = seed_a;
  assign seed[1] = seed_b;
  assign load[0] = load_a;
  assign load[1] = load_b;

  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      if (reset) begin
        state[k] <= seed_reset;
      end else if (load[k]) begin
        // all-zero state would lock up
        state[k] <= (seed[k] == 32'd0) ? 32'd1 : seed[k];
      end else if (enable) begin
        state[k] <= lfsr_next(state[k]);
      end
    end
  end

  assign rnda = state[0];
  assign rndb = state[1];

endmodule

`default_nettype wire

//--- adc_emu.sv
`timescale 1ns/1ps
`default_nettype none

module adc_emu #(
  // 0 field, 1 forward, 2 reflect
  parameter int sel = 0
) (
  input  logic                                clk,
  input  logic                                reset,
  cav_probe_if.snk                            probe,
  input  station_pkg::adc_t                   offset,
  input  logic [station_pkg::dither_bits-1:0] rnd,
  input  logic                                dither_on,
  output station_pkg::adc_t                   adc,
  output logic                                strobe
);
  import station_pkg::*;

  sample_t pick;
  wide_t dither;
  wide_t sum;

  // probe channel chosen at elaboration
  always_comb begin
    case (sel)
      0: pick = probe.field;
      1: pick = probe.forward;
      default: pick = probe.reflect;
    endcase
  end

  // dither is a signed nibble, -8 to +7
  assign dither = dither_on ? wide_t'($signed(rnd)) : '0;

  // drop two lsbs to reach 16 bits, then add offset and dither
  assign sum = wide_t'(pick >>> 2) + wide_t'(offset) + dither;

  always_ff @(posedge clk) begin
    if (reset) begin
      adc <= '0;
      strobe <= 1'b0;
    end else begin
      adc <= sat_adc(sum);
      strobe <= probe.iq;
    end
  end

endmodule

`default_nettype wire

//--- station.sv
`timescale 1ns/1ps
`default_nettype none

module station (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       iq,
  input  station_pkg::sample_t       drive,
  input  logic                       lb_write,
  input  station_regs_pkg::lb_addr_t lb_addr,
  input  station_regs_pkg::lb_data_t lb_data,
  output station_pkg::adc_t          a_field,
  output station_pkg::adc_t          a_forward,
  output station_pkg::adc_t          a_reflect,
  output logic                       adc_iq
);
  import station_pkg::*;
  import station_regs_pkg::*;

  // configuration from the register block
  sample_t knee;
  shift_t amp_shift;
  logic [17:0] cav_gain;
  shift_t cav_shift;
  adc_t offset_field;
  adc_t offset_forward;
  adc_t offset_reflect;
  logic prng_enable;
  logic [31:0] seed_a;
  logic [31:0] seed_b;
  logic seed_load_a;
  logic seed_load_b;

  // amplifier chain
  sample_t comp_out;
  logic comp_iq;
  sample_t amp_out;
  logic amp_iq;

  logic [31:0] rnda;
  logic [31:0] rndb;

  cav_probe_if probe();

  station_regs u_regs (
    .clk, .reset, .lb_write, .lb_addr, .lb_data,
    .knee, .amp_shift, .cav_gain, .cav_shift,
    .offset_field, .offset_forward, .offset_reflect,
    .prng_enable, .seed_a, .seed_b, .seed_load_a, .seed_load_b
  );

  amp_compress u_compress (
    .clk, .reset, .d_in(drive), .iq, .knee, .d_out(comp_out), .iq_out(comp_iq)
  );

  amp_lowpass u_lowpass (
    .clk, .reset, .d_in(comp_out), .iq(comp_iq), .shift(amp_shift),
    .d_out(amp_out), .iq_out(amp_iq)
  );

  cav_mode u_cav (
    .clk, .reset, .drive(amp_out), .iq(amp_iq), .gain(cav_gain), .shift(cav_shift),
    .probe(probe.src)
  );

  noise_prng u_prng (
    .clk, .reset, .enable(prng_enable), .seed_a, .seed_b,
    .load_a(seed_load_a), .load_b(seed_load_b), .rnda, .rndb
  );

  // field converter also supplies the output phase strobe
  adc_emu #(.sel(0)) u_adc_field (
    .clk, .reset, .probe(probe.snk), .offset(offset_field), .rnd(rnda[3:0]),
    .dither_on(prng_enable), .adc(a_field), .strobe(adc_iq)
  );

  adc_emu #(.sel(1)) u_adc_forward (
    .clk, .reset, .probe(probe.snk), .offset(offset_forward), .rnd(rnda[19:16]),
    .dither_on(prng_enable), .adc(a_forward), .strobe()
  );

  adc_emu #(.sel(2)) u_adc_reflect (
    .clk, .reset, .probe(probe.snk), .offset(offset_reflect), .rnd(rndb[3:0]),
    .dither_on(prng_enable), .adc(a_reflect), .strobe()
  );

endmodule

`default_nettype wire

//--- station_chk.sv
`timescale 1ns/1ps
`default_nettype none

module station_chk (
  input logic                     clk,
  input logic                     reset,
  input logic                     adc_iq,
  input station_pkg::adc_t        a_field,
  input station_pkg::adc_t        a_forward,
  input station_pkg::adc_t        a_reflect,
  input logic                     prng_enable,
  input logic                     seed_load_a,
  input logic                     seed_load_b,
  input logic [31:0]              rnda,
  input logic [31:0]              rndb
);

  // set once the first I phase reaches the outputs
  logic started;

  always_ff @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
    end else if (adc_iq) begin
      started <= 1'b1;
    end
  end

  // output phase alternates I, Q, I, ...
  a_phase_toggle: assert property (@(posedge clk) disable iff (reset)
    started |=> adc_iq != $past(adc_iq))
    else $error("adc_iq stopped alternating");

  a_outputs_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({a_field, a_forward, a_reflect}))
    else $error("ADC output is unknown");

  // a seed load may still move a stopped generator
  a_prng_hold: assert property (@(posedge clk) disable iff (reset)
    !prng_enable && !seed_load_a && !seed_load_b |=> $stable(rnda) && $stable(rndb))
    else $error("PRNG moved while disabled");

endmodule

bind station station_chk u_chk (
  .clk, .reset, .adc_iq, .a_field, .a_forward, .a_reflect,
  .prng_enable, .seed_load_a, .seed_load_b, .rnda, .rndb
);

`default_nettype wire

//--- station_tb.sv
`timescale 1ns/1ps
`default_nettype none

module station_tb;
  import station_pkg::*;
  import station_regs_pkg::*;

  logic clk;
  logic reset;
  logic iq;
  sample_t drive;
  logic lb_write;
  lb_addr_t lb_addr;
  lb_data_t lb_data;
  adc_t a_field;
  adc_t a_forward;
  adc_t a_reflect;
  logic adc_iq;

  int errors;
  int tests;
  int errors_at_start;
  string test_name;

  // drive held for each phase, ph is the phase of the next sample
  longint drv_i;
  longint drv_q;
  logic ph;

  // reference copies of the configuration registers
  longint m_knee;
  longint m_amp_shift;
  longint m_gain;
  longint m_cav_shift;
  longint m_off [3];
  logic m_dither;

  // reference pipeline, one set per registered stage
  longint c_d;
  longint l_d;
  longint l_st_i;
  longint l_st_q;
  longint f_st_i;
  longint f_st_q;
  longint p_field;
  longint p_fwd;
  longint p_refl;
  longint o_val [3];
  logic c_iq;
  logic l_iq;
  logic p_iq;
  logic o_iq;
  logic o_dith;

  station i_dut (
    .clk, .reset, .iq, .drive, .lb_write, .lb_addr, .lb_data,
    .a_field, .a_forward, .a_reflect, .adc_iq
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // hard stop in case the stimulus stalls
  initial begin
    #200000;
    $display("timeout: simulation did not finish in time");
    $display("Test failures found");
    $finish;
  end

  function automatic longint sat(input longint x, input longint hi, input longint lo);
    if (x > hi) return hi;
    if (x < lo) return lo;
    return x;
  endfunction

  // above the knee only half the excess passes
  function automatic longint compress(input longint d, input longint knee);
    longint mag;
    mag = (d < 0) ? -d : d;
    if (mag <= knee) return d;
    mag = knee + (mag - knee) / 2;
    return sat((d < 0) ? -mag : mag, sample_max, sample_min);
  endfunction

  // drop two bits, add offset, clamp to 16 bits
  function automatic longint adc_rule(input longint x, input longint off);
    return sat((x >>> 2) + off, adc_max, adc_min);
  endfunction

  function automatic sample_t rand_sample();
    return sample_t'($urandom);
  endfunction

  task automatic model_reset();
    m_knee = sample_max;
    m_amp_shift = 2;
    m_gain = 0;
    m_cav_shift = 4;
    m_off = '{0, 0, 0};
    m_dither = 1'b0;
    {c_d, l_d, l_st_i, l_st_q, f_st_i, f_st_q} = '0;
    {p_field, p_fwd, p_refl} = '0;
    o_val = '{0, 0, 0};
    {c_iq, l_iq, p_iq, o_iq, o_dith, ph} = '0;
  endtask

  // one rising edge of the reference, later stages first
  task automatic model_edge();
    longint tgt;
    longint fnew;
    longint lnew;
    o_val[0] = adc_rule(p_field, m_off[0]);
    o_val[1] = adc_rule(p_fwd, m_off[1]);
    o_val[2] = adc_rule(p_refl, m_off[2]);
    o_iq = p_iq;
    o_dith = m_dither;
    // cavity pulls its field toward the scaled forward wave
    tgt = (l_d * m_gain) >>> 17;
    fnew = l_iq ? f_st_i : f_st_q;
    fnew = fnew + ((tgt - fnew) >>> m_cav_shift);
    if (l_iq) f_st_i = fnew;
    else f_st_q = fnew;
    p_field = fnew;
    p_fwd = l_d;
    p_refl = sat(fnew - l_d, sample_max, sample_min);
    p_iq = l_iq;
    // amplifier low-pass, state per phase
    lnew = c_iq ? l_st_i : l_st_q;
    lnew = lnew + ((c_d - lnew) >>> m_amp_shift);
    if (c_iq) l_st_i = lnew;
    else l_st_q = lnew;
    l_d = lnew;
    l_iq = c_iq;
    c_d = compress(drive, m_knee);
    c_iq = iq;
    // a write on this edge only reaches later samples
    if (lb_write) begin
      case (lb_addr)
        addr_knee: m_knee = longint'(sample_t'(lb_data[17:0]));
        addr_amp_shift: m_amp_shift = lb_data[3:0];
        addr_cav_gain: m_gain = lb_data[17:0];
        addr_cav_shift: m_cav_shift = lb_data[3:0];
        addr_adc_offset_field: m_off[0] = longint'(adc_t'(lb_data[15:0]));
        addr_adc_offset_forward: m_off[1] = longint'(adc_t'(lb_data[15:0]));
        addr_adc_offset_reflect: m_off[2] = longint'(adc_t'(lb_data[15:0]));
        addr_prng_enable: m_dither = lb_data[0];
        default: ;
      endcase
    end
  endtask

  task automatic compare_adc(input string what, input adc_t expected, input adc_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_phase(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // dithered output may sit -8 to +7 away from the clean value
  task automatic compare_dither(input string what, input adc_t clean, input adc_t actual);
    int diff;
    diff = int'(actual) - int'(clean);
    if ($isunknown(actual) || diff < -8 || diff > 7) begin
      $display("[FAIL] %s %s: expected %0d -8..+7, actual %0d", test_name, what, clean, actual);
      errors++;
    end
  endtask

  // called at a falling edge, returns at the next one
  task automatic tick();
    if (o_dith) begin
      compare_dither("field", adc_t'(o_val[0]), a_field);
      compare_dither("forward", adc_t'(o_val[1]), a_forward);
      compare_dither("reflect", adc_t'(o_val[2]), a_reflect);
    end else begin
      compare_adc("field", adc_t'(o_val[0]), a_field);
      compare_adc("forward", adc_t'(o_val[1]), a_forward);
      compare_adc("reflect", adc_t'(o_val[2]), a_reflect);
    end
    compare_phase("adc_iq", o_iq, adc_iq);
    ph = ~ph;
    iq = ph;
    drive = sample_t'(ph ? drv_i : drv_q);
    model_edge();
    @(negedge clk);
  endtask

  task automatic bus_write(input lb_addr_t addr, input lb_data_t data);
    lb_write = 1'b1;
    lb_addr = addr;
    lb_data = data;
    tick();
    lb_write = 1'b0;
  endtask

  // constant drive with both filter shifts at zero settles at once
  task automatic settle_const(input logic want_iq, input longint d);
    longint fwd;
    longint fld;
    adc_t ef;
    adc_t ew;
    adc_t er;
    int n;
    fwd = compress(d, m_knee);
    fld = (fwd * m_gain) >>> 17;
    ef = adc_t'(adc_rule(fld, m_off[0]));
    ew = adc_t'(adc_rule(fwd, m_off[1]));
    er = adc_t'(adc_rule(sat(fld - fwd, sample_max, sample_min), m_off[2]));
    for (n = 0; n < 64; n++) begin
      if (adc_iq === want_iq && a_field === ef && a_forward === ew && a_reflect === er)
        break;
      tick();
    end
    if (n == 64) begin
      $display("%s: outputs never settled on phase %b for drive %0d", test_name, want_iq, d);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("%s done, %0d errors", test_name, errors - errors_at_start);
  endtask

  task automatic set_filters(input lb_data_t gain);
    bus_write(addr_amp_shift, 0);
    bus_write(addr_cav_shift, 0);
    bus_write(addr_cav_gain, gain);
  endtask

  task automatic set_offsets(input int off);
    bus_write(addr_adc_offset_field, off);
    bus_write(addr_adc_offset_forward, off);
    bus_write(addr_adc_offset_reflect, off);
  endtask

  task automatic test_reset();
    logic prev;
    begin_test("reset");
    drv_i = 0;
    drv_q = 0;
    repeat (8) tick();
    bus_write(addr_adc_offset_field, 100);
    bus_write(addr_adc_offset_forward, -200);
    bus_write(addr_adc_offset_reflect, 300);
    settle_const(1'b1, 0);
    settle_const(1'b0, 0);
    for (int k = 0; k < 4; k++) begin
      prev = adc_iq;
      tick();
      compare_phase("alternate", ~prev, adc_iq);
    end
    end_test();
  endtask

  task automatic test_compress();
    longint vals [4];
    begin_test("compress");
    vals = '{50000, -50000, sample_max, sample_min};
    set_filters(0);
    set_offsets(0);
    bus_write(addr_knee, 20000);
    foreach (vals[k]) begin
      drv_i = vals[k];
      drv_q = vals[k];
      settle_const(1'b1, vals[k]);
      settle_const(1'b0, vals[k]);
    end
    end_test();
  endtask

  // random settings and drive, every cycle compared with the reference
  task automatic test_random();
    begin_test("random");
    for (int r = 0; r < 5; r++) begin
      bus_write(addr_amp_shift, $urandom % 8);
      bus_write(addr_cav_gain, $urandom % 131073);
      bus_write(addr_cav_shift, $urandom % 8);
      bus_write(addr_knee, 60000 + $urandom % 70000);
      for (int k = 0; k < 150; k++) begin
        drv_i = rand_sample();
        drv_q = rand_sample();
        tick();
      end
    end
    end_test();
  endtask

  task automatic test_iq();
    begin_test("iq");
    bus_write(addr_knee, sample_max);
    set_filters(1 << 16);
    drv_i = 40000;
    drv_q = -30000;
    settle_const(1'b1, 40000);
    settle_const(1'b0, -30000);
    settle_const(1'b1, 40000);
    end_test();
  endtask

  // unity and zero gain with both offset signs reach every clamp
  task automatic test_saturate();
    int gains [2];
    int offs [2];
    begin_test("saturate");
    gains = '{131072, 0};
    offs = '{30000, -30000};
    drv_i = sample_max;
    drv_q = sample_min;
    foreach (gains[g]) begin
      foreach (offs[o]) begin
        set_filters(gains[g]);
        set_offsets(offs[o]);
        settle_const(1'b1, sample_max);
        settle_const(1'b0, sample_min);
      end
    end
    end_test();
  endtask

  task automatic test_dither();
    adc_t rec [32][3];
    int changed [3];
    begin_test("dither");
    set_filters(1 << 16);
    set_offsets(0);
    drv_i = 20000;
    drv_q = -12000;
    settle_const(1'b1, 20000);
    settle_const(1'b0, -12000);
    bus_write(addr_prng_enable, 1);
    bus_write(addr_seed_a, 32'h1234);
    bus_write(addr_seed_b, 32'h5678);
    // second load lands one edge later, then the converters register it
    repeat (2) tick();
    changed = '{0, 0, 0};
    for (int k = 0; k < 32; k++) begin
      rec[k] = '{a_field, a_forward, a_reflect};
      if (k >= 2) begin
        for (int c = 0; c < 3; c++) begin
          if (rec[k][c] != rec[k - 2][c]) changed[c]++;
        end
      end
      tick();
    end
    foreach (changed[c]) begin
      if (changed[c] == 0) begin
        $display("%s: output %0d never varied with the PRNG on", test_name, c);
        errors++;
      end
    end
    // same seeds and same drive must replay the same sequence
    bus_write(addr_seed_a, 32'h1234);
    bus_write(addr_seed_b, 32'h5678);
    repeat (2) tick();
    for (int k = 0; k < 32; k++) begin
      compare_adc("replay field", rec[k][0], a_field);
      compare_adc("replay forward", rec[k][1], a_forward);
      compare_adc("replay reflect", rec[k][2], a_reflect);
      tick();
    end
    end_test();
  endtask

  initial begin
    void'($urandom(32'h7fd));
    errors = 0;
    tests = 0;
    reset = 1'b1;
    iq = 1'b0;
    drive = '0;
    lb_write = 1'b0;
    lb_addr = '0;
    lb_data = '0;
    drv_i = 0;
    drv_q = 0;
    model_reset();
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_compress();
    test_random();
    test_iq();
    test_saturate();
    test_dither();
    $display("%0d tests run, %0d checks failed", tests, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- station.f
station_pkg.sv
station_regs_pkg.sv
cav_probe_if.sv
station_regs.sv
amp_compress.sv
amp_lowpass.sv
cav_mode.sv
noise_prng.sv
adc_emu.sv
station.sv
station_chk.sv
station_tb.sv
